//--- include/asym_fifo_settings.svh
`ifndef ASYM_FIFO_SETTINGS_SVH
`define ASYM_FIFO_SETTINGS_SVH

// write side pushes bytes, read side pops words
`define W_DATA_W 8
`define R_DATA_W 32

// byte address width, 64 bytes = 16 words
`define ADDR_W 6

// apb address space
`define APB_ADDR_W 4

// register map
`define REG_DATA 4'h0
`define REG_STATUS 4'h4

`endif

//--- design/asym_fifo_pkg.sv
`include "asym_fifo_settings.svh"

package asym_fifo_pkg;

   // one pushed byte
   typedef logic [`W_DATA_W-1:0] byte_t;

   // one popped word, also the apb data width
   typedef logic [`R_DATA_W-1:0] word_t;

   // fill level in bytes, one extra bit to hold the full count
   typedef logic [`ADDR_W:0] level_t;

   typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

   // apb transfer phase as seen by the slave
   typedef enum logic [1:0] {
      PH_IDLE,
      PH_SETUP,
      PH_ACCESS
   } apb_phase_t;

endpackage

//--- design/fifo_wr_if.sv
`timescale 1ns/1ps

interface fifo_wr_if;

   // single-cycle push request and its byte
   logic w_en;
   asym_fifo_pkg::byte_t w_data;

   // status back from the fifo core
   logic w_full;
   asym_fifo_pkg::level_t level;

   modport regs (
      output w_en,
      output w_data,
      input  w_full,
      input  level
   );

   modport fifo (
      input  w_en,
      input  w_data,
      output w_full,
      output level
   );

endinterface

//--- design/ram_2p_asym.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module ram_2p_asym (
   input  logic                        clk,

   // byte write port
   input  logic                        w_en,
   input  logic [`ADDR_W-1:0]          w_addr,
   input  asym_fifo_pkg::byte_t        w_data,

   // word read port
   input  logic                        r_en,
   input  logic [`ADDR_W-3:0]          r_addr,
   output asym_fifo_pkg::word_t        r_data
);

   localparam int LANES = `R_DATA_W / `W_DATA_W;
   localparam int LANE_W = $clog2(LANES);
   localparam int WORDS = 1 << (`ADDR_W - LANE_W);

   // entry index for the byte port
   logic [`ADDR_W-LANE_W-1:0] w_entry;
   logic [LANE_W-1:0]         w_lane;

   // all lanes of the addressed entry
   asym_fifo_pkg::word_t      rd_word;

   assign w_entry = w_addr[`ADDR_W-1:LANE_W];
   assign w_lane  = w_addr[LANE_W-1:0];

   // one byte-wide memory per lane
   // lane 0 holds the first byte of each word
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      asym_fifo_pkg::byte_t mem [0:WORDS-1];

      always_ff @(posedge clk) begin
         if (w_en && (w_lane == LANE_W'(l))) begin
            mem[w_entry] <= w_data;
         end
      end

      assign rd_word[l*`W_DATA_W +: `W_DATA_W] = mem[r_addr];
   end

   // registered read, holds between reads
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= rd_word;
      end
   end

endmodule

//--- design/fifo_sync_asym.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module fifo_sync_asym (
   input  logic                 clk,
   input  logic                 arst_n,

   // write side from the register block
   fifo_wr_if.fifo              wr,

   // read side
   input  logic                 r_en,
   output asym_fifo_pkg::word_t r_data,
   output logic                 r_empty
);

   // width ratio between the wide and the narrow port
   localparam int RATIO = (`R_DATA_W > `W_DATA_W) ? (`R_DATA_W / `W_DATA_W)
                                                  : (`W_DATA_W / `R_DATA_W);
   localparam int R_ADDR_W = `ADDR_W - $clog2(RATIO);

   // level steps per access, in bytes
   localparam asym_fifo_pkg::level_t W_INCR =
      asym_fifo_pkg::level_t'((`W_DATA_W > `R_DATA_W) ? RATIO : 1);
   localparam asym_fifo_pkg::level_t R_INCR =
      asym_fifo_pkg::level_t'((`R_DATA_W > `W_DATA_W) ? RATIO : 1);
   localparam asym_fifo_pkg::level_t FIFO_SIZE = asym_fifo_pkg::level_t'(1) << `ADDR_W;

   logic                  w_en_int;
   logic                  r_en_int;
   logic [`ADDR_W-1:0]    w_addr;
   logic [R_ADDR_W-1:0]   r_addr;
   asym_fifo_pkg::level_t level_q;
   asym_fifo_pkg::level_t level_nxt;
   asym_fifo_pkg::word_t  ram_r_data;
   logic                  rd_valid;

   // accesses only count when the flags allow them
   assign w_en_int = wr.w_en & ~wr.w_full;
   assign r_en_int = r_en & ~r_empty;

   // address counters wrap naturally at the memory size
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         w_addr <= '0;
         r_addr <= '0;
      end else begin
         if (w_en_int) begin
            w_addr <= w_addr + 1'b1;
         end
         if (r_en_int) begin
            r_addr <= r_addr + 1'b1;
         end
      end
   end

   // +1 on a push, -4 on a pop, -3 on both
   always_comb begin
      level_nxt = level_q;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         level_q  <= '0;
         rd_valid <= 1'b0;
      end else begin
         level_q <= level_nxt;
         // first pop makes the read register meaningful
         if (r_en_int) begin
            rd_valid <= 1'b1;
         end
      end
   end

   // empty while less than a whole word is held
   assign r_empty  = level_q < R_INCR;
   assign wr.w_full = level_q > (FIFO_SIZE - W_INCR);
   assign wr.level  = level_q;

   // read register of the ram has no reset, show zero until the first pop
   assign r_data = rd_valid ? ram_r_data : '0;

   ram_2p_asym i_ram_2p_asym (
      .clk    (clk),
      .w_en   (w_en_int),
      .w_addr (w_addr),
      .w_data (wr.w_data),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (ram_r_data)
   );

   a_level_max: assert property (@(posedge clk) disable iff (!arst_n)
      level_q <= FIFO_SIZE)
      else $error("fifo level above capacity");

   // a pop never leaves more than a push could have added, catches a wrap
   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      r_en_int |=> level_q < ($past(level_q) + W_INCR))
      else $error("fifo level wrapped below zero");

endmodule

//--- design/fifo_apb_regs.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module fifo_apb_regs (
   input  logic                      clk,
   input  logic                      arst_n,

   // apb slave
   input  asym_fifo_pkg::apb_addr_t  paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  asym_fifo_pkg::word_t      pwdata,
   output asym_fifo_pkg::word_t      prdata,
   output logic                      pready,
   output logic                      pslverr,

   // fifo status and write side
   input  logic                      r_empty,
   fifo_wr_if.regs                   wr
);

   // status word layout
   localparam int ST_EMPTY_BIT = 8;
   localparam int ST_FULL_BIT = 9;

   asym_fifo_pkg::apb_phase_t phase;
   asym_fifo_pkg::apb_phase_t phase_q;
   logic                      access;
   logic                      sel_data;
   logic                      sel_status;
   logic                      data_wr;
   logic                      status_rd;
   asym_fifo_pkg::word_t      status_word;

   // phase of the current cycle
   always_comb begin
      if (!psel) begin
         phase = asym_fifo_pkg::PH_IDLE;
      end else if (!penable) begin
         phase = asym_fifo_pkg::PH_SETUP;
      end else begin
         phase = asym_fifo_pkg::PH_ACCESS;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase_q <= asym_fifo_pkg::PH_IDLE;
      end else begin
         phase_q <= phase;
      end
   end

   // an access only counts right after its setup cycle
   assign access = (phase == asym_fifo_pkg::PH_ACCESS) &&
                   (phase_q == asym_fifo_pkg::PH_SETUP);

   // address decode
   assign sel_data   = (paddr == `REG_DATA);
   assign sel_status = (paddr == `REG_STATUS);

   assign data_wr   = access & sel_data & pwrite;
   assign status_rd = access & sel_status & ~pwrite;

   // push pulse, the core drops it when full
   assign wr.w_en   = data_wr;
   assign wr.w_data = pwdata[`W_DATA_W-1:0];

   always_comb begin
      status_word = '0;
      status_word[`ADDR_W:0] = wr.level;
      status_word[ST_EMPTY_BIT] = r_empty;
      status_word[ST_FULL_BIT] = wr.w_full;
   end

   assign prdata = status_rd ? status_word : '0;

   // no wait states
   assign pready = 1'b1;

   // anything but a status read or an accepted push is an error
   assign pslverr = access & ~(status_rd | (data_wr & ~wr.w_full));

   a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
      penable |-> psel)
      else $error("penable without psel");

   a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (psel && !penable) ##1 (psel && penable) |-> $stable(paddr))
      else $error("paddr changed between setup and access");

endmodule

//--- design/asym_fifo_top.sv
`timescale 1ns/1ps

module asym_fifo_top (
   input  logic                     clk,
   input  logic                     arst_n,

   // apb slave
   input  asym_fifo_pkg::apb_addr_t paddr,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  asym_fifo_pkg::word_t     pwdata,
   output asym_fifo_pkg::word_t     prdata,
   output logic                     pready,
   output logic                     pslverr,

   // word read port
   input  logic                     r_en,
   output asym_fifo_pkg::word_t     r_data,
   output logic                     r_empty
);

   // push path and fifo status between regs and core
   fifo_wr_if wr_if ();

   fifo_apb_regs i_fifo_apb_regs (
      .clk     (clk),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .r_empty (r_empty),
      .wr      (wr_if.regs)
   );

   // empty flag also feeds the status register
   fifo_sync_asym i_fifo_sync_asym (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr      (wr_if.fifo),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty)
   );

endmodule

//--- verification/tb_asym_fifo.sv
`timescale 1ns/1ps
`include "asym_fifo_settings.svh"

module tb_asym_fifo;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 3;
   localparam int DEPTH_BYTES = 1 << `ADDR_W;
   localparam int BYTES_PER_WORD = `R_DATA_W / `W_DATA_W;
   localparam int RANDOM_OPS = 80;

   typedef enum logic [1:0] {
      OP_PUSH,
      OP_STATUS,
      OP_POP,
      OP_BAD
   } op_kind_t;

   logic                      clk;
   logic                      arst_n;
   asym_fifo_pkg::apb_addr_t  paddr;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   asym_fifo_pkg::word_t      pwdata;
   asym_fifo_pkg::word_t      prdata;
   logic                      pready;
   logic                      pslverr;
   logic                      r_en;
   asym_fifo_pkg::word_t      r_data;
   logic                      r_empty;

   // operation table with one entry per bus access or pop
   op_kind_t                  op_kind[$];
   logic [31:0]               op_data[$];
   logic [31:0]               op_exp[$];
   string                     op_name[$];

   // byte queue model of the fifo contents
   asym_fifo_pkg::byte_t      model_q[$];
   asym_fifo_pkg::word_t      model_word;
   string                     section;

   logic [31:0]               rng_state;
   int                        cycle_count;
   int                        cycle_limit;

   asym_fifo_top i_asym_fifo_top (
      .clk     (clk),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // watchdog on the whole run
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the table did not complete", cycle_count);
         $display(">>> FAIL");
         $fatal(1, "simulation timeout");
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // status word with level in 6:0, empty in 8 and full in 9
   function automatic logic [31:0] model_status();
      logic [31:0] st;
      st = '0;
      st[`ADDR_W:0] = asym_fifo_pkg::level_t'(model_q.size());
      st[8] = model_q.size() < BYTES_PER_WORD;
      st[9] = model_q.size() >= DEPTH_BYTES;
      return st;
   endfunction

   // a push is dropped with an error once 64 bytes are held
   function automatic void add_push(input logic [31:0] data);
      op_kind.push_back(OP_PUSH);
      op_data.push_back(data);
      op_name.push_back(section);
      if (model_q.size() < DEPTH_BYTES) begin
         model_q.push_back(data[`W_DATA_W-1:0]);
         op_exp.push_back(32'd0);
      end else begin
         op_exp.push_back(32'd1);
      end
   endfunction

   function automatic void add_status();
      op_kind.push_back(OP_STATUS);
      op_data.push_back(32'd0);
      op_name.push_back(section);
      op_exp.push_back(model_status());
   endfunction

   // first byte pushed lands in bits 7:0 and an empty pop keeps the old word
   function automatic void add_pop();
      op_kind.push_back(OP_POP);
      op_data.push_back(32'd0);
      op_name.push_back(section);
      if (model_q.size() >= BYTES_PER_WORD) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            model_word[b*`W_DATA_W +: `W_DATA_W] = model_q[b];
         end
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            void'(model_q.pop_front());
         end
      end
      op_exp.push_back(model_word);
   endfunction

   // data holds the write flag in bit 4 and the address below it
   function automatic void add_bad(input logic [3:0] addr, input logic write);
      op_kind.push_back(OP_BAD);
      op_data.push_back({27'b0, write, addr});
      op_name.push_back(section);
      op_exp.push_back(32'd1);
   endfunction

   function automatic void build_table();
      logic [31:0] r;
      section = "packing";
      add_pop();
      add_status();
      add_push(32'hffff_ff11);
      add_push(32'h0000_0022);
      add_push(32'h1234_5633);
      add_push(32'h0000_0044);
      add_status();
      add_pop();
      add_status();

      section = "level";
      add_push(32'h0000_00a1);
      add_status();
      add_push(32'h0000_00b2);
      add_push(32'h0000_00c3);
      add_status();
      section = "empty pop";
      add_pop();
      add_status();
      section = "level";
      add_push(32'h0000_00d4);
      add_status();
      add_pop();
      add_status();

      section = "full";
      for (int i = 0; i < DEPTH_BYTES; i++) begin
         add_push({24'h5a5a5a, 8'(i * 37 + 5)});
      end
      add_status();
      add_push(32'h0000_00ee);
      add_status();
      for (int i = 0; i < DEPTH_BYTES / BYTES_PER_WORD; i++) begin
         add_pop();
      end
      add_status();

      section = "bus errors";
      add_bad(`REG_DATA, 1'b0);
      add_bad(`REG_STATUS, 1'b1);
      add_bad(4'h8, 1'b0);
      add_bad(4'hc, 1'b1);
      add_status();

      section = "mixed traffic";
      for (int i = 0; i < RANDOM_OPS; i++) begin
         r = next_random();
         if (r[2:0] == 3'd0) begin
            add_pop();
         end else if (r[2:0] == 3'd7) begin
            add_status();
         end else begin
            add_push(next_random());
         end
      end
      add_status();
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   // setup, access, then back to idle
   task automatic apb_transfer(input asym_fifo_pkg::apb_addr_t addr, input logic write,
                               input asym_fifo_pkg::word_t wdata, output logic err,
                               output asym_fifo_pkg::word_t rdata);
      @(posedge clk);
      #1;
      paddr = addr;
      pwrite = write;
      pwdata = wdata;
      psel = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      err = pslverr;
      rdata = prdata;
      check("pready", 32'd1, {31'b0, pready});
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   // r_data is registered and read after the pop edge
   task automatic pop_word(output asym_fifo_pkg::word_t data);
      @(posedge clk);
      #1;
      r_en = 1'b1;
      @(posedge clk);
      #1;
      r_en = 1'b0;
      @(negedge clk);
      data = r_data;
   endtask

   initial begin
      logic                 err;
      asym_fifo_pkg::word_t rdata;
      arst_n = 1'b0;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      r_en = 1'b0;
      rng_state = 32'd23224;
      model_word = '0;
      cycle_count = 0;
      build_table();
      cycle_limit = 4 * op_kind.size() + 100;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;

      for (int i = 0; i < op_kind.size(); i++) begin
         case (op_kind[i])
            OP_PUSH: begin
               apb_transfer(`REG_DATA, 1'b1, op_data[i], err, rdata);
               check($sformatf("%s op %0d push pslverr", op_name[i], i),
                     op_exp[i], {31'b0, err});
            end
            OP_STATUS: begin
               apb_transfer(`REG_STATUS, 1'b0, '0, err, rdata);
               check($sformatf("%s op %0d status pslverr", op_name[i], i),
                     32'd0, {31'b0, err});
               check($sformatf("%s op %0d status word", op_name[i], i), op_exp[i], rdata);
               check($sformatf("%s op %0d r_empty", op_name[i], i),
                     {31'b0, op_exp[i][8]}, {31'b0, r_empty});
            end
            OP_POP: begin
               pop_word(rdata);
               check($sformatf("%s op %0d r_data", op_name[i], i), op_exp[i], rdata);
            end
            OP_BAD: begin
               apb_transfer(op_data[i][3:0], op_data[i][4], 32'h0000_00a5, err, rdata);
               check($sformatf("%s op %0d pslverr", op_name[i], i),
                     op_exp[i], {31'b0, err});
            end
         endcase
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- asym_fifo.f
+incdir+include
design/asym_fifo_pkg.sv
design/fifo_wr_if.sv
design/ram_2p_asym.sv
design/fifo_sync_asym.sv
design/fifo_apb_regs.sv
design/asym_fifo_top.sv
verification/tb_asym_fifo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the asym_fifo testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_asym_fifo \
   -f asym_fifo.f \
   -o sim_asym_fifo

# the simulation stops with a non-zero status on failure, the search decides
sim_out=$(./obj_dir/sim_asym_fifo 2>&1) || true
echo "$sim_out"

if grep -qxF '>>> PASS' <<< "$sim_out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
